//--- hw/obi_pkg.sv
/* OBI bus package
   widths and response timing shared by every master and slave port */
package obi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W = DATA_W / 8;

  // core data port and DMA channel in the full design
  localparam int NUM_MASTERS = 2;

  // cycles from the grant edge to rvalid, on every port
  localparam int RSP_LATENCY = 1;

endpackage

//--- hw/mcu_pkg.sv
/* MCU memory map package
   address windows, RAM bank geometry, register offsets and slave indices */
package mcu_pkg;

  // two RAM banks back to back
  localparam logic [31:0] RAM0_BASE = 32'h0000_0000;
  localparam logic [31:0] RAM1_BASE = 32'h0000_1000;
  localparam int RAM_BANK_BYTES = 4096;
  localparam int RAM_BANKS = 2;
  localparam int RAM_WORDS = RAM_BANK_BYTES / 4;
  localparam int RAM_WORD_W = $clog2(RAM_WORDS);
  localparam int RAM_BANK_BIT = $clog2(RAM1_BASE - RAM0_BASE);
  localparam int RAM_BANK_SEL_W = $clog2(RAM_BANKS);
  localparam logic [31:0] RAM_SIZE = 32'(RAM_BANKS * RAM_BANK_BYTES);

  localparam logic [31:0] AO_BASE = 32'h2000_0000;
  localparam logic [31:0] AO_SIZE = 32'h0000_1000;
  localparam logic [31:0] PERIPH_BASE = 32'h3000_0000;
  localparam logic [31:0] PERIPH_SIZE = 32'h0000_1000;
  localparam int REG_OFF_W = 12;

  // always-on registers
  localparam logic [REG_OFF_W-1:0] EXIT_VALUE = 12'h000;
  localparam logic [REG_OFF_W-1:0] EXIT_VALID = 12'h004;
  localparam logic [REG_OFF_W-1:0] BOOT_SEL = 12'h008;
  localparam logic [REG_OFF_W-1:0] SCRATCH = 12'h00C;

  // gpio registers
  localparam logic [REG_OFF_W-1:0] GPIO_OUT = 12'h000;
  localparam logic [REG_OFF_W-1:0] GPIO_EN = 12'h004;
  localparam logic [REG_OFF_W-1:0] GPIO_IN = 12'h008;

  localparam int NUM_SLAVES = 4;
  localparam int SLV_W = $clog2(NUM_SLAVES);
  localparam logic [SLV_W-1:0] SLV_RAM = 2'd0;
  localparam logic [SLV_W-1:0] SLV_AO = 2'd1;
  localparam logic [SLV_W-1:0] SLV_PERIPH = 2'd2;
  localparam logic [SLV_W-1:0] SLV_NONE = 2'd3;

endpackage

//--- hw/system_bus.sv
/* system bus crossbar
   two OBI masters to four slaves, round-robin arbitration per slave */
`timescale 1ns/1ps

module system_bus
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              m0_req_i,
  input  logic [ADDR_W-1:0] m0_addr_i,
  input  logic              m0_we_i,
  input  logic [BE_W-1:0]   m0_be_i,
  input  logic [DATA_W-1:0] m0_wdata_i,
  output logic              m0_gnt_o,
  output logic              m0_rvalid_o,
  output logic [DATA_W-1:0] m0_rdata_o,

  input  logic              m1_req_i,
  input  logic [ADDR_W-1:0] m1_addr_i,
  input  logic              m1_we_i,
  input  logic [BE_W-1:0]   m1_be_i,
  input  logic [DATA_W-1:0] m1_wdata_i,
  output logic              m1_gnt_o,
  output logic              m1_rvalid_o,
  output logic [DATA_W-1:0] m1_rdata_o,

  output logic              ram_req_o,
  output logic [ADDR_W-1:0] ram_addr_o,
  output logic              ram_we_o,
  output logic [BE_W-1:0]   ram_be_o,
  output logic [DATA_W-1:0] ram_wdata_o,
  input  logic              ram_rvalid_i,
  input  logic [DATA_W-1:0] ram_rdata_i,

  output logic              ao_req_o,
  output logic [ADDR_W-1:0] ao_addr_o,
  output logic              ao_we_o,
  output logic [BE_W-1:0]   ao_be_o,
  output logic [DATA_W-1:0] ao_wdata_o,
  input  logic              ao_rvalid_i,
  input  logic [DATA_W-1:0] ao_rdata_i,

  output logic              periph_req_o,
  output logic [ADDR_W-1:0] periph_addr_o,
  output logic              periph_we_o,
  output logic [BE_W-1:0]   periph_be_o,
  output logic [DATA_W-1:0] periph_wdata_o,
  input  logic              periph_rvalid_i,
  input  logic [DATA_W-1:0] periph_rdata_i
);

  logic [SLV_W-1:0]       mst_sel   [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] rsp_valid;
  logic [DATA_W-1:0]      rsp_rdata [NUM_MASTERS];

  logic [NUM_SLAVES-1:0]  slv_req;
  logic [NUM_SLAVES-1:0]  slv_win;
  logic [ADDR_W-1:0]      slv_addr  [NUM_SLAVES];
  logic [NUM_SLAVES-1:0]  slv_we;
  logic [BE_W-1:0]        slv_be    [NUM_SLAVES];
  logic [DATA_W-1:0]      slv_wdata [NUM_SLAVES];
  logic [NUM_SLAVES-1:0]  slv_rvalid;
  logic [DATA_W-1:0]      slv_rdata [NUM_SLAVES];

  // priority holder and last served master, per slave
  logic [NUM_SLAVES-1:0]  rr_ptr_q;
  logic [NUM_SLAVES-1:0]  served_q;
  logic                   none_rvalid_q;

  function automatic logic [SLV_W-1:0] decode(input logic [ADDR_W-1:0] addr);
    logic [SLV_W-1:0] sel;
    if ((addr - RAM0_BASE) < RAM_SIZE) begin
      sel = SLV_RAM;
    end else if ((addr - AO_BASE) < AO_SIZE) begin
      sel = SLV_AO;
    end else if ((addr - PERIPH_BASE) < PERIPH_SIZE) begin
      sel = SLV_PERIPH;
    end else begin
      sel = SLV_NONE;
    end
    return sel;
  endfunction

  assign mst_sel[0] = decode(m0_addr_i);
  assign mst_sel[1] = decode(m1_addr_i);

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_arb
    logic hit0;
    logic hit1;

    assign hit0 = m0_req_i && (mst_sel[0] == SLV_W'(s));
    assign hit1 = m1_req_i && (mst_sel[1] == SLV_W'(s));

    // master 1 wins when alone or when it holds the priority
    assign slv_win[s]   = hit1 && (!hit0 || rr_ptr_q[s]);
    assign slv_req[s]   = hit0 || hit1;
    assign slv_addr[s]  = slv_win[s] ? m1_addr_i : m0_addr_i;
    assign slv_we[s]    = slv_win[s] ? m1_we_i : m0_we_i;
    assign slv_be[s]    = slv_win[s] ? m1_be_i : m0_be_i;
    assign slv_wdata[s] = slv_win[s] ? m1_wdata_i : m0_wdata_i;
  end

  // slaves are always ready, so only arbitration holds a master off
  assign m0_gnt_o = m0_req_i && !slv_win[mst_sel[0]];
  assign m1_gnt_o = m1_req_i && slv_win[mst_sel[1]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q      <= '0;
      served_q      <= '0;
      none_rvalid_q <= 1'b0;
    end else begin
      for (int s = 0; s < NUM_SLAVES; s++) begin
        if (slv_req[s]) begin
          rr_ptr_q[s] <= !slv_win[s];
          served_q[s] <= slv_win[s];
        end
      end
      none_rvalid_q <= slv_req[SLV_NONE];
    end
  end

  // at most one slave answers each master per cycle
  always_comb begin
    rsp_valid = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      rsp_rdata[m] = '0;
    end
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (slv_rvalid[s]) begin
        rsp_valid[served_q[s]] = 1'b1;
        rsp_rdata[served_q[s]] = slv_rdata[s];
      end
    end
  end

  assign m0_rvalid_o = rsp_valid[0];
  assign m0_rdata_o  = rsp_rdata[0];
  assign m1_rvalid_o = rsp_valid[1];
  assign m1_rdata_o  = rsp_rdata[1];

  assign ram_req_o      = slv_req[SLV_RAM];
  assign ram_addr_o     = slv_addr[SLV_RAM];
  assign ram_we_o       = slv_we[SLV_RAM];
  assign ram_be_o       = slv_be[SLV_RAM];
  assign ram_wdata_o    = slv_wdata[SLV_RAM];
  assign ao_req_o       = slv_req[SLV_AO];
  assign ao_addr_o      = slv_addr[SLV_AO];
  assign ao_we_o        = slv_we[SLV_AO];
  assign ao_be_o        = slv_be[SLV_AO];
  assign ao_wdata_o     = slv_wdata[SLV_AO];
  assign periph_req_o   = slv_req[SLV_PERIPH];
  assign periph_addr_o  = slv_addr[SLV_PERIPH];
  assign periph_we_o    = slv_we[SLV_PERIPH];
  assign periph_be_o    = slv_be[SLV_PERIPH];
  assign periph_wdata_o = slv_wdata[SLV_PERIPH];

  assign slv_rvalid[SLV_RAM]    = ram_rvalid_i;
  assign slv_rdata[SLV_RAM]     = ram_rdata_i;
  assign slv_rvalid[SLV_AO]     = ao_rvalid_i;
  assign slv_rdata[SLV_AO]      = ao_rdata_i;
  assign slv_rvalid[SLV_PERIPH] = periph_rvalid_i;
  assign slv_rdata[SLV_PERIPH]  = periph_rdata_i;

  // unmapped space reads zero and drops writes
  assign slv_rvalid[SLV_NONE] = none_rvalid_q;
  assign slv_rdata[SLV_NONE]  = '0;

endmodule

//--- hw/memory_subsystem.sv
/* memory subsystem
   two word-wide RAM banks, byte-enable writes, read data one cycle later */
`timescale 1ns/1ps

module memory_subsystem
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]         mem [RAM_BANKS][RAM_WORDS];
  logic [RAM_BANK_SEL_W-1:0] bank;
  logic [RAM_WORD_W-1:0]     word;
  logic                      rvalid_q;
  logic [DATA_W-1:0]         rdata_q;

  // bank from the bit at the bank size, word below it
  assign bank = addr_i[RAM_BANK_BIT +: RAM_BANK_SEL_W];
  assign word = addr_i[2 +: RAM_WORD_W];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem[bank][word][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    // writes answer with zero data
    rdata_q <= (req_i && !we_i) ? mem[bank][word] : '0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

//--- hw/ao_peripheral_subsystem.sv
/* always-on peripheral block
   program exit value and flag, boot-select readback, scratch word */
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  input  logic              boot_select_i,
  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o
);

  logic [REG_OFF_W-1:0] off;
  logic                 wr;
  logic [DATA_W-1:0]    exit_value_q;
  logic                 exit_valid_q;
  logic [DATA_W-1:0]    scratch_q;
  logic [DATA_W-1:0]    rdata_d;
  logic [DATA_W-1:0]    rdata_q;
  logic                 rvalid_q;

  assign off = addr_i[REG_OFF_W-1:0];
  assign wr  = req_i && we_i;

  always_comb begin
    case (off)
      EXIT_VALUE: rdata_d = exit_value_q;
      EXIT_VALID: rdata_d = DATA_W'(exit_valid_q);
      BOOT_SEL:   rdata_d = DATA_W'(boot_select_i);
      SCRATCH:    rdata_d = scratch_q;
      default:    rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (wr && (off == EXIT_VALUE)) begin
        exit_value_q <= wdata_i;
      end
      // sticky, only reset clears it
      if (wr && (off == EXIT_VALID) && wdata_i[0]) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && (off == SCRATCH)) begin
      scratch_q <= wdata_i;
    end
    rdata_q <= (req_i && !we_i) ? rdata_d : '0;
  end

  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

//--- hw/peripheral_subsystem.sv
/* peripheral block
   32-bit GPIO port with output and enable registers, synchronized input */
`timescale 1ns/1ps

module peripheral_subsystem
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  input  logic [DATA_W-1:0] gpio_i,
  output logic [DATA_W-1:0] gpio_o,
  output logic [DATA_W-1:0] gpio_en_o
);

  logic [REG_OFF_W-1:0] off;
  logic                 wr;
  logic [DATA_W-1:0]    gpio_out_q;
  logic [DATA_W-1:0]    gpio_en_q;
  logic [DATA_W-1:0]    gpio_meta_q;
  logic [DATA_W-1:0]    gpio_sync_q;
  logic [DATA_W-1:0]    rdata_d;
  logic [DATA_W-1:0]    rdata_q;
  logic                 rvalid_q;

  assign off = addr_i[REG_OFF_W-1:0];
  assign wr  = req_i && we_i;

  // GPIO_IN is read only
  always_comb begin
    case (off)
      GPIO_OUT: rdata_d = gpio_out_q;
      GPIO_EN:  rdata_d = gpio_en_q;
      GPIO_IN:  rdata_d = gpio_sync_q;
      default:  rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_q <= '0;
      gpio_en_q  <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (wr && (off == GPIO_OUT)) begin
        gpio_out_q <= wdata_i;
      end
      if (wr && (off == GPIO_EN)) begin
        gpio_en_q <= wdata_i;
      end
    end
  end

  // two-stage input sync
  always_ff @(posedge clk_i) begin
    gpio_meta_q <= gpio_i;
    gpio_sync_q <= gpio_meta_q;
    rdata_q     <= (req_i && !we_i) ? rdata_d : '0;
  end

  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign gpio_o    = gpio_out_q;
  assign gpio_en_o = gpio_en_q;

endmodule

//--- hw/mini_mcu.sv
/* mini MCU top level
   bus crossbar over RAM, always-on and GPIO peripheral subsystems */
`timescale 1ns/1ps

module mini_mcu
  import obi_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              m0_req_i,
  input  logic [ADDR_W-1:0] m0_addr_i,
  input  logic              m0_we_i,
  input  logic [BE_W-1:0]   m0_be_i,
  input  logic [DATA_W-1:0] m0_wdata_i,
  output logic              m0_gnt_o,
  output logic              m0_rvalid_o,
  output logic [DATA_W-1:0] m0_rdata_o,

  input  logic              m1_req_i,
  input  logic [ADDR_W-1:0] m1_addr_i,
  input  logic              m1_we_i,
  input  logic [BE_W-1:0]   m1_be_i,
  input  logic [DATA_W-1:0] m1_wdata_i,
  output logic              m1_gnt_o,
  output logic              m1_rvalid_o,
  output logic [DATA_W-1:0] m1_rdata_o,

  input  logic              boot_select_i,
  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o,

  input  logic [DATA_W-1:0] gpio_i,
  output logic [DATA_W-1:0] gpio_o,
  output logic [DATA_W-1:0] gpio_en_o
);

  // ram slave
  logic              ram_req;
  logic [ADDR_W-1:0] ram_addr;
  logic              ram_we;
  logic [BE_W-1:0]   ram_be;
  logic [DATA_W-1:0] ram_wdata;
  logic              ram_rvalid;
  logic [DATA_W-1:0] ram_rdata;

  // always-on slave
  logic              ao_req;
  logic [ADDR_W-1:0] ao_addr;
  logic              ao_we;
  logic [DATA_W-1:0] ao_wdata;
  logic              ao_rvalid;
  logic [DATA_W-1:0] ao_rdata;

  // gpio slave
  logic              periph_req;
  logic [ADDR_W-1:0] periph_addr;
  logic              periph_we;
  logic [DATA_W-1:0] periph_wdata;
  logic              periph_rvalid;
  logic [DATA_W-1:0] periph_rdata;

  // master ports connect by name
  system_bus system_bus_i (
    .*,
    .ram_req_o      (ram_req),
    .ram_addr_o     (ram_addr),
    .ram_we_o       (ram_we),
    .ram_be_o       (ram_be),
    .ram_wdata_o    (ram_wdata),
    .ram_rvalid_i   (ram_rvalid),
    .ram_rdata_i    (ram_rdata),
    .ao_req_o       (ao_req),
    .ao_addr_o      (ao_addr),
    .ao_we_o        (ao_we),
    .ao_be_o        (),
    .ao_wdata_o     (ao_wdata),
    .ao_rvalid_i    (ao_rvalid),
    .ao_rdata_i     (ao_rdata),
    .periph_req_o   (periph_req),
    .periph_addr_o  (periph_addr),
    .periph_we_o    (periph_we),
    .periph_be_o    (),
    .periph_wdata_o (periph_wdata),
    .periph_rvalid_i(periph_rvalid),
    .periph_rdata_i (periph_rdata)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .rst_i,
    .req_i   (ram_req),
    .addr_i  (ram_addr),
    .we_i    (ram_we),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rvalid_o(ram_rvalid),
    .rdata_o (ram_rdata)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .rst_i,
    .req_i   (ao_req),
    .addr_i  (ao_addr),
    .we_i    (ao_we),
    .wdata_i (ao_wdata),
    .rvalid_o(ao_rvalid),
    .rdata_o (ao_rdata),
    .boot_select_i,
    .exit_value_o,
    .exit_valid_o
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i,
    .rst_i,
    .req_i   (periph_req),
    .addr_i  (periph_addr),
    .we_i    (periph_we),
    .wdata_i (periph_wdata),
    .rvalid_o(periph_rvalid),
    .rdata_o (periph_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_en_o
  );

endmodule

//--- testbench/mini_mcu_checker.sv
/* mini MCU bus checker
   concurrent assertions on the OBI handshake and the always-on outputs */
`timescale 1ns/1ps

module mini_mcu_checker
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input logic              clk_i,
  input logic              rst_i,
  input logic              m0_req_i,
  input logic [ADDR_W-1:0] m0_addr_i,
  input logic              m0_gnt_i,
  input logic              m0_rvalid_i,
  input logic              m1_req_i,
  input logic [ADDR_W-1:0] m1_addr_i,
  input logic              m1_gnt_i,
  input logic              m1_rvalid_i,
  input logic              exit_valid_i
);

  int unsigned fail_cnt = 0;
  logic        m0_ram;
  logic        m1_ram;

  assign m0_ram = m0_req_i && ((m0_addr_i - RAM0_BASE) < RAM_SIZE);
  assign m1_ram = m1_req_i && ((m1_addr_i - RAM0_BASE) < RAM_SIZE);

  // grant only answers a request
  m0_gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    m0_gnt_i |-> m0_req_i) else begin $error("m0 grant without request"); fail_cnt++; end
  m1_gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    m1_gnt_i |-> m1_req_i) else begin $error("m1 grant without request"); fail_cnt++; end

  // response exactly one cycle after each grant
  m0_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    m0_gnt_i |=> m0_rvalid_i) else begin $error("m0 grant without rvalid"); fail_cnt++; end
  m1_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    m1_gnt_i |=> m1_rvalid_i) else begin $error("m1 grant without rvalid"); fail_cnt++; end
  m0_no_stray_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    m0_rvalid_i |-> $past(m0_gnt_i)) else begin $error("m0 stray rvalid"); fail_cnt++; end
  m1_no_stray_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    m1_rvalid_i |-> $past(m1_gnt_i)) else begin $error("m1 stray rvalid"); fail_cnt++; end

  // held-off master keeps its address
  m0_addr_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (m0_req_i && !m0_gnt_i) |=> $stable(m0_addr_i))
    else begin $error("m0 address moved while held off"); fail_cnt++; end
  m1_addr_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (m1_req_i && !m1_gnt_i) |=> $stable(m1_addr_i))
    else begin $error("m1 address moved while held off"); fail_cnt++; end

  exit_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    exit_valid_i |=> exit_valid_i) else begin $error("exit_valid_o dropped"); fail_cnt++; end

  ram_one_winner: assert property (@(posedge clk_i) disable iff (rst_i)
    !(m0_ram && m1_ram && m0_gnt_i && m1_gnt_i))
    else begin $error("both masters granted at RAM"); fail_cnt++; end

endmodule

bind mini_mcu mini_mcu_checker i_checker (
  .clk_i,
  .rst_i,
  .m0_req_i,
  .m0_addr_i,
  .m0_gnt_i    (m0_gnt_o),
  .m0_rvalid_i (m0_rvalid_o),
  .m1_req_i,
  .m1_addr_i,
  .m1_gnt_i    (m1_gnt_o),
  .m1_rvalid_i (m1_rvalid_o),
  .exit_valid_i(exit_valid_o)
);

//--- testbench/tb_mini_mcu.sv
/* mini MCU testbench
   drives both bus masters, mirrors the RAM and checks every read */
`timescale 1ns/1ps

module tb_mini_mcu
  import obi_pkg::*;
  import mcu_pkg::*;
();

  localparam int N_RAM = 24;
  localparam int N_RR = 6;
  // transactions per test, for the watchdog
  localparam int TOTAL_TXNS = 3 * N_RAM + (2 * N_RR + 6) + 7 + 12;
  localparam int WATCHDOG_CYCLES = TOTAL_TXNS * 20;

  localparam logic [31:0] EXIT_VALUE_ADDR = AO_BASE + 32'(EXIT_VALUE);
  localparam logic [31:0] EXIT_VALID_ADDR = AO_BASE + 32'(EXIT_VALID);
  localparam logic [31:0] BOOT_SEL_ADDR = AO_BASE + 32'(BOOT_SEL);
  localparam logic [31:0] SCRATCH_ADDR = AO_BASE + 32'(SCRATCH);
  localparam logic [31:0] GPIO_OUT_ADDR = PERIPH_BASE + 32'(GPIO_OUT);
  localparam logic [31:0] GPIO_EN_ADDR = PERIPH_BASE + 32'(GPIO_EN);
  localparam logic [31:0] GPIO_IN_ADDR = PERIPH_BASE + 32'(GPIO_IN);
  // would alias SCRATCH if decode were wrong
  localparam logic [31:0] UNMAPPED_ADDR = 32'h4000_000C;

  logic              clk;
  logic              rst;
  logic [1:0]        req;
  logic [ADDR_W-1:0] addr [2];
  logic [1:0]        we;
  logic [BE_W-1:0]   be [2];
  logic [DATA_W-1:0] wdata [2];
  logic [1:0]        gnt;
  logic [1:0]        rvalid;
  logic [DATA_W-1:0] rdata [2];
  logic              boot_select;
  logic [DATA_W-1:0] gpio_in;
  logic [DATA_W-1:0] exit_value;
  logic              exit_valid;
  logic [DATA_W-1:0] gpio_out;
  logic [DATA_W-1:0] gpio_en;

  logic [DATA_W-1:0] ref_mem [RAM_BANKS * RAM_WORDS];
  logic [ADDR_W-1:0] written [$];
  int                gnt_order [$];
  time               gnt_time [2];
  int unsigned       check_fails;
  int unsigned       errs_before;
  int unsigned       tests_passed;
  int unsigned       tests_failed;

  mini_mcu i_dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .m0_req_i     (req[0]),
    .m0_addr_i    (addr[0]),
    .m0_we_i      (we[0]),
    .m0_be_i      (be[0]),
    .m0_wdata_i   (wdata[0]),
    .m0_gnt_o     (gnt[0]),
    .m0_rvalid_o  (rvalid[0]),
    .m0_rdata_o   (rdata[0]),
    .m1_req_i     (req[1]),
    .m1_addr_i    (addr[1]),
    .m1_we_i      (we[1]),
    .m1_be_i      (be[1]),
    .m1_wdata_i   (wdata[1]),
    .m1_gnt_o     (gnt[1]),
    .m1_rvalid_o  (rvalid[1]),
    .m1_rdata_o   (rdata[1]),
    .boot_select_i(boot_select),
    .exit_value_o (exit_value),
    .exit_valid_o (exit_valid),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic int unsigned errors();
    return check_fails + i_dut.i_checker.fail_cnt;
  endfunction

  function automatic int ram_index(input logic [ADDR_W-1:0] a);
    return int'((a - RAM0_BASE) >> 2);
  endfunction

  function automatic logic [ADDR_W-1:0] ram_addr(input int bank);
    logic [ADDR_W-1:0] base;
    base = (bank == 0) ? RAM0_BASE : RAM1_BASE;
    return base + 32'($urandom_range(RAM_WORDS - 1) << 2);
  endfunction

  // only enabled bytes take the new data
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [BE_W-1:0] en);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (en[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_data(input string what, input logic [31:0] where,
                            input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t ns: %s addr 0x%08h expected 0x%08h got 0x%08h",
               $time, what, where, exp, act);
      check_fails++;
    end
  endtask

  // one bus transfer, started and finished on a rising edge
  task automatic access(input int m, input logic [ADDR_W-1:0] a, input logic w,
                        input logic [BE_W-1:0] en, input logic [DATA_W-1:0] d,
                        output logic [DATA_W-1:0] rd);
    req[m]   <= 1'b1;
    addr[m]  <= a;
    we[m]    <= w;
    be[m]    <= en;
    wdata[m] <= d;
    do begin
      @(posedge clk);
    end while (!gnt[m]);
    gnt_order.push_back(m);
    gnt_time[m] = $time;
    req[m] <= 1'b0;
    @(posedge clk);
    rd = rvalid[m] ? rdata[m] : 'x;
  endtask

  task automatic reg_write(input int m, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] rd;
    access(m, a, 1'b1, 4'hf, d, rd);
    check_data("write response", a, '0, rd);
  endtask

  task automatic reg_read(input int m, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] rd;
    access(m, a, 1'b0, '0, '0, rd);
    check_data("register read", a, exp, rd);
  endtask

  task automatic ram_write(input int m, input logic [ADDR_W-1:0] a,
                           input logic [BE_W-1:0] en, input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] rd;
    access(m, a, 1'b1, en, d, rd);
    check_data("write response", a, '0, rd);
    ref_mem[ram_index(a)] = merge_bytes(ref_mem[ram_index(a)], d, en);
  endtask

  task automatic ram_read(input int m, input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] rd;
    access(m, a, 1'b0, '0, '0, rd);
    check_data("ram read", a, ref_mem[ram_index(a)], rd);
  endtask

  task automatic finish_test(input string name);
    int unsigned errs;
    errs = errors() - errs_before;
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
    errs_before = errors();
  endtask

  initial begin
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] scratch;
    rst = 1'b1;
    req = '0;
    we = '0;
    boot_select = 1'b0;
    gpio_in = '0;
    for (int i = 0; i < 2; i++) begin
      addr[i] = '0;
      be[i] = '0;
      wdata[i] = '0;
    end
    check_fails = 0;
    errs_before = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(32'hdbe8_6cf6));
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    check_data("exit_valid_o", '0, '0, 32'(exit_valid));
    check_data("exit_value_o", '0, '0, exit_value);
    check_data("gpio_o", '0, '0, gpio_out);
    check_data("gpio_en_o", '0, '0, gpio_en);
    finish_test("reset state");

    // full words into both banks, then partial overwrites
    for (int i = 0; i < N_RAM; i++) begin
      a = ram_addr(i % 2);
      written.push_back(a);
      ram_write(int'($urandom_range(1)), a, 4'hf, $urandom);
    end
    for (int i = 0; i < N_RAM; i++) begin
      a = written[$urandom_range(N_RAM - 1)];
      ram_write(int'($urandom_range(1)), a, 4'($urandom_range(1, 14)), $urandom);
    end
    for (int i = 0; i < N_RAM; i++) begin
      ram_read(int'($urandom_range(1)), written[i]);
    end
    finish_test("ram");

    // last RAM grant to master 1 hands priority to master 0
    ram_read(1, written[0]);
    gnt_order.delete();
    for (int r = 0; r < N_RR; r++) begin
      fork
        ram_read(0, written[2 * r]);
        ram_read(1, written[2 * r + 1]);
      join
    end
    foreach (gnt_order[i]) begin
      check_data("grant order", i, i % 2, gnt_order[i]);
    end
    // master 0 served last, so master 1 wins the next contest
    ram_read(0, written[0]);
    gnt_order.delete();
    fork
      ram_read(0, written[1]);
      ram_read(1, written[2]);
    join
    check_data("grant order", '0, 32'd1, gnt_order[0]);
    fork
      ram_read(0, written[0]);
      reg_read(1, GPIO_OUT_ADDR, '0);
    join
    assert (gnt_time[0] == gnt_time[1]) else begin
      $display("RAM and PERIPH grants came in different cycles, %0t and %0t",
               gnt_time[0], gnt_time[1]);
      check_fails++;
    end
    finish_test("concurrent access");

    v = $urandom;
    reg_write(0, EXIT_VALUE_ADDR, v);
    reg_write(1, EXIT_VALID_ADDR, 32'h1);
    check_data("exit_value_o", EXIT_VALUE_ADDR, v, exit_value);
    check_data("exit_valid_o", EXIT_VALID_ADDR, 32'h1, 32'(exit_valid));
    reg_read(0, EXIT_VALID_ADDR, 32'h1);
    scratch = $urandom;
    reg_write(1, SCRATCH_ADDR, scratch);
    reg_read(0, SCRATCH_ADDR, scratch);
    boot_select <= 1'b0;
    reg_read(1, BOOT_SEL_ADDR, 32'h0);
    boot_select <= 1'b1;
    reg_read(0, BOOT_SEL_ADDR, 32'h1);
    finish_test("always-on");

    v = $urandom;
    w = $urandom;
    reg_write(0, GPIO_OUT_ADDR, v);
    reg_write(1, GPIO_EN_ADDR, w);
    check_data("gpio_o", GPIO_OUT_ADDR, v, gpio_out);
    check_data("gpio_en_o", GPIO_EN_ADDR, w, gpio_en);
    reg_read(0, GPIO_OUT_ADDR, v);
    reg_read(1, GPIO_EN_ADDR, w);
    // two sync stages, then the read edge
    a = $urandom;
    gpio_in <= a;
    repeat (2) @(posedge clk);
    reg_read(0, GPIO_IN_ADDR, a);
    reg_write(1, GPIO_IN_ADDR, ~a);
    reg_read(0, GPIO_IN_ADDR, a);
    reg_read(1, UNMAPPED_ADDR, '0);
    reg_write(0, UNMAPPED_ADDR, $urandom);
    reg_read(1, UNMAPPED_ADDR, '0);
    reg_read(0, SCRATCH_ADDR, scratch);
    reg_read(1, GPIO_OUT_ADDR, v);
    finish_test("gpio and unmapped");

    repeat (2) @(posedge clk);
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors() == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
hw/obi_pkg.sv
hw/mcu_pkg.sv
hw/system_bus.sv
hw/memory_subsystem.sv
hw/ao_peripheral_subsystem.sv
hw/peripheral_subsystem.sv
hw/mini_mcu.sv
testbench/mini_mcu_checker.sv
testbench/tb_mini_mcu.sv

//--- Makefile
# Verilator build and run for the mini MCU testbench

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SIM      := $(BUILD_DIR)/V$(TOP)
SRCS     := $(wildcard hw/*.sv testbench/*.sv)
FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
